// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    ////////////////////////////////////////
    // geometry
    ////////////////////////////////////////

    localparam int INDEX_W    = 4;
    localparam int OFFSET_W   = 2;
    localparam int WAYS       = 2;
    localparam int LINE_WORDS = 4;
    // address bits above index, word offset and byte offset
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W - 2;
    localparam int SETS       = 1 << INDEX_W;

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    typedef logic [31:0]            addr_t;
    typedef logic [31:0]            word_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [INDEX_W-1:0]     index_t;
    typedef logic [OFFSET_W-1:0]    offset_t;
    // word 0 sits in the low 32 bits
    typedef word_t [LINE_WORDS-1:0] line_t;
    typedef logic [WAYS-1:0]        way_mask_t;

    typedef enum logic {
        OP_INV_SET = 1'b0,
        OP_INV_ALL = 1'b1
    } cache_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        OP_EXEC
    } ctrl_state_e;

    ////////////////////////////////////////
    // pipeline side bundles
    ////////////////////////////////////////

    typedef struct packed {
        addr_t     addr;
        logic      uncached;
        // maintenance request, op says which one
        logic      is_op;
        cache_op_e op;
    } fetch_req_t;

    typedef struct packed {
        addr_t pc;
        word_t instr0;
        word_t instr1;
        logic  instr1_valid;
    } fetch_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/icache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
    input  logic                  clk,
    input  logic                  arst_n,
    input  icache_pkg::index_t    rd_index,
    input  icache_pkg::tag_t      cmp_tag,
    output icache_pkg::way_mask_t hit,
    input  icache_pkg::way_mask_t wr_en,
    input  icache_pkg::index_t    wr_index,
    input  icache_pkg::tag_t      wr_tag,
    input  logic                  inv_set,
    input  logic                  inv_all,
    input  icache_pkg::index_t    inv_index
);
    import icache_pkg::*;

    tag_t                       tag_mem [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0]  valid;
    index_t                     idx_q;

    // index of the set being looked up
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_q <= '0;
        end else begin
            idx_q <= rd_index;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wr_en[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
        end
    end

    // invalidate all wins over a refill in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (inv_all) begin
                    valid[w] <= '0;
                end else begin
                    if (inv_set) begin
                        valid[w][inv_index] <= 1'b0;
                    end
                    if (wr_en[w]) begin
                        valid[w][wr_index] <= 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = valid[w][idx_q] && (tag_mem[w][idx_q] == cmp_tag);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_data_array (
    input  logic                  clk,
    input  icache_pkg::index_t    rd_index,
    output icache_pkg::line_t     rd_line0,
    output icache_pkg::line_t     rd_line1,
    input  icache_pkg::way_mask_t wr_en,
    input  icache_pkg::index_t    wr_index,
    input  icache_pkg::line_t     wr_line
);
    import icache_pkg::*;

    line_t line_mem [WAYS][SETS];

    // whole line written per way on refill
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wr_en[w]) begin
                line_mem[w][wr_index] <= wr_line;
            end
        end
    end

    // both ways read together, result one cycle later
    always_ff @(posedge clk) begin
        rd_line0 <= line_mem[0][rd_index];
        rd_line1 <= line_mem[1][rd_index];
    end

endmodule

`default_nettype wire

// ==== hdl/icache_lru.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_lru (
    input  logic               clk,
    input  logic               arst_n,
    input  icache_pkg::index_t index,
    input  logic               touch,
    input  logic               touch_way,
    output logic               victim
);
    import icache_pkg::*;

    // bit set names the least recently used way
    logic [SETS-1:0] lru_bits;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_bits <= '0;
        end else if (touch) begin
            lru_bits[index] <= ~touch_way;
        end
    end

    assign victim = lru_bits[index];

endmodule

`default_nettype wire

// ==== hdl/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  icache_pkg::fetch_req_t buf_req,
    input  logic                   stall,
    input  icache_pkg::way_mask_t  hit,
    input  logic                   victim,
    input  logic                   mem_addr_ok,
    input  logic                   mem_data_ok,
    output logic                   buf_load,
    output logic                   mem_req,
    output icache_pkg::way_mask_t  data_we,
    output icache_pkg::way_mask_t  tag_we,
    output logic                   inv_set,
    output logic                   inv_all,
    output logic                   lru_touch,
    output logic                   lru_way,
    output logic                   rsp_valid,
    output logic                   sel_return,
    output logic                   sel_way
);
    import icache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        rsp_valid_q;
    logic        lookup_hit;
    logic        refill_done;
    logic        allocate;
    way_mask_t   victim_mask;

    ////////////////////////////////////////
    // decode of the current cycle
    ////////////////////////////////////////

    // lookup only resolves once the pipeline is not stalling
    assign lookup_hit = (state == LOOKUP) && !stall && !buf_req.is_op
                        && !buf_req.uncached && (|hit);

    // data may come with addr_ok when memory has zero latency
    assign refill_done = mem_data_ok
                         && ((state == MISS_WAIT) || ((state == MISS_REQ) && mem_addr_ok));

    assign allocate    = refill_done && !buf_req.uncached;
    assign victim_mask = way_mask_t'(1) << victim;

    assign req_ready = !stall && ((state == IDLE) || lookup_hit);
    assign buf_load  = req_valid && req_ready;
    assign mem_req   = (state == MISS_REQ);

    assign data_we = allocate ? victim_mask : '0;
    assign tag_we  = allocate ? victim_mask : '0;

    assign inv_set = (state == OP_EXEC) && (buf_req.op == OP_INV_SET);
    assign inv_all = (state == OP_EXEC) && (buf_req.op == OP_INV_ALL);

    assign lru_touch = lookup_hit || allocate;
    assign lru_way   = lookup_hit ? hit[1] : victim;

    // miss data goes straight out, hits come from the response register
    assign sel_return = refill_done;
    assign sel_way    = hit[1];
    assign rsp_valid  = refill_done || rsp_valid_q;

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (buf_load) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!stall) begin
                    if (buf_req.is_op) begin
                        state_nxt = OP_EXEC;
                    end else if (lookup_hit) begin
                        // back to back fetch stays in lookup
                        state_nxt = buf_load ? LOOKUP : IDLE;
                    end else begin
                        state_nxt = MISS_REQ;
                    end
                end
            end
            MISS_REQ: begin
                if (refill_done) begin
                    state_nxt = IDLE;
                end else if (mem_addr_ok) begin
                    state_nxt = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (refill_done) begin
                    state_nxt = IDLE;
                end
            end
            OP_EXEC: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // presented response held while stall is high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            state       <= state_nxt;
            rsp_valid_q <= (stall && rsp_valid) || lookup_hit;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_fetch_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_align (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load,
    input  logic                   stall,
    input  icache_pkg::fetch_req_t req,
    output icache_pkg::fetch_req_t buf_req,
    input  icache_pkg::line_t      line0,
    input  icache_pkg::line_t      line1,
    input  icache_pkg::line_t      mem_line,
    input  logic                   sel_return,
    input  logic                   sel_way,
    output icache_pkg::fetch_rsp_t rsp,
    output icache_pkg::addr_t      mem_addr
);
    import icache_pkg::*;

    line_t      src_line;
    offset_t    word_sel;
    fetch_rsp_t rsp_now;
    fetch_rsp_t rsp_q;

    // request buffer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_req <= '0;
        end else if (load) begin
            buf_req <= req;
        end
    end

    assign word_sel = buf_req.addr[2 +: OFFSET_W];

    // exact word for uncached, line aligned for refill
    assign mem_addr = buf_req.uncached ? {buf_req.addr[31:2], 2'b00}
                    : {buf_req.addr[31:OFFSET_W+2], {(OFFSET_W + 2){1'b0}}};

    assign src_line = sel_return ? mem_line : (sel_way ? line1 : line0);

    ////////////////////////////////////////
    // dual issue alignment
    ////////////////////////////////////////

    // second word only when it shares the half line
    always_comb begin
        rsp_now.pc           = buf_req.addr;
        rsp_now.instr1       = '0;
        rsp_now.instr1_valid = 1'b0;
        if (buf_req.uncached) begin
            rsp_now.instr0 = src_line[0];
        end else begin
            rsp_now.instr0 = src_line[word_sel];
            if (!word_sel[0]) begin
                rsp_now.instr1       = src_line[offset_t'(word_sel + 1'b1)];
                rsp_now.instr1_valid = 1'b1;
            end
        end
    end

    // output register, frozen by stall
    always_ff @(posedge clk) begin
        rsp_q <= stall ? rsp : rsp_now;
    end

    assign rsp = sel_return ? rsp_now : rsp_q;

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    input  icache_pkg::fetch_req_t req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output icache_pkg::fetch_rsp_t rsp,
    input  logic                   stall,
    output logic                   mem_req,
    output icache_pkg::addr_t      mem_addr,
    output logic                   mem_uncached,
    input  logic                   mem_addr_ok,
    input  logic                   mem_data_ok,
    input  icache_pkg::line_t      mem_rdata
);
    import icache_pkg::*;

    fetch_req_t buf_req;
    way_mask_t  hit;
    way_mask_t  data_we;
    way_mask_t  tag_we;
    line_t      line0;
    line_t      line1;
    index_t     rd_index;
    index_t     buf_index;
    tag_t       buf_tag;
    logic       buf_load;
    logic       victim;
    logic       inv_set;
    logic       inv_all;
    logic       lru_touch;
    logic       lru_way;
    logic       sel_return;
    logic       sel_way;

    assign buf_index    = buf_req.addr[OFFSET_W+2 +: INDEX_W];
    assign buf_tag      = buf_req.addr[31 -: TAG_W];
    assign mem_uncached = buf_req.uncached;

    // arrays follow the incoming fetch, otherwise keep the buffered set
    assign rd_index = buf_load ? req.addr[OFFSET_W+2 +: INDEX_W] : buf_index;

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    icache_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .buf_req     (buf_req),
        .stall       (stall),
        .hit         (hit),
        .victim      (victim),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .buf_load    (buf_load),
        .mem_req     (mem_req),
        .data_we     (data_we),
        .tag_we      (tag_we),
        .inv_set     (inv_set),
        .inv_all     (inv_all),
        .lru_touch   (lru_touch),
        .lru_way     (lru_way),
        .rsp_valid   (rsp_valid),
        .sel_return  (sel_return),
        .sel_way     (sel_way)
    );

    icache_fetch_align u_align (
        .clk        (clk),
        .arst_n     (arst_n),
        .load       (buf_load),
        .stall      (stall),
        .req        (req),
        .buf_req    (buf_req),
        .line0      (line0),
        .line1      (line1),
        .mem_line   (mem_rdata),
        .sel_return (sel_return),
        .sel_way    (sel_way),
        .rsp        (rsp),
        .mem_addr   (mem_addr)
    );

    icache_tag_array u_tags (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_index  (rd_index),
        .cmp_tag   (buf_tag),
        .hit       (hit),
        .wr_en     (tag_we),
        .wr_index  (buf_index),
        .wr_tag    (buf_tag),
        .inv_set   (inv_set),
        .inv_all   (inv_all),
        .inv_index (buf_index)
    );

    icache_data_array u_data (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_line0 (line0),
        .rd_line1 (line1),
        .wr_en    (data_we),
        .wr_index (buf_index),
        .wr_line  (mem_rdata)
    );

    icache_lru u_lru (
        .clk       (clk),
        .arst_n    (arst_n),
        .index     (buf_index),
        .touch     (lru_touch),
        .touch_way (lru_way),
        .victim    (victim)
    );

endmodule

`default_nettype wire

// ==== verif/icache_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== verif/icache_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model #(
    parameter logic [31:0] DATA_KEY = 32'h0
) (
    input  logic              clk,
    input  logic              mem_req,
    input  icache_pkg::addr_t mem_addr,
    input  logic              mem_uncached,
    output logic              mem_addr_ok,
    output logic              mem_data_ok,
    output icache_pkg::line_t mem_rdata
);
    import icache_pkg::*;

    logic [15:0] lfsr = 16'd70;
    addr_t       req_addr;
    logic        req_unc;
    int          lat;

    // two random bits, 0 to 3 cycles
    function automatic int rand_latency();
        int v;
        v = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic word_t word_at(addr_t a);
        return {2'b00, a[31:2]} ^ DATA_KEY;
    endfunction

    initial begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(posedge clk);
            #10;
            if (mem_req) begin
                req_addr = mem_addr;
                req_unc  = mem_uncached;
                repeat (rand_latency()) begin
                    @(posedge clk);
                    #10;
                end
                mem_addr_ok = 1'b1;
                lat = rand_latency();
                // zero data latency gives data_ok together with addr_ok
                if (lat != 0) begin
                    @(posedge clk);
                    #10;
                    mem_addr_ok = 1'b0;
                    repeat (lat - 1) begin
                        @(posedge clk);
                        #10;
                    end
                end
                for (int i = 0; i < LINE_WORDS; i++) begin
                    mem_rdata[i] = req_unc ? ((i == 0) ? word_at(req_addr) : '0)
                                 : word_at({req_addr[31:4], i[1:0], 2'b00});
                end
                mem_data_ok = 1'b1;
                @(posedge clk);
                #10;
                mem_addr_ok = 1'b0;
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int    CLK_PERIOD = 100;
    localparam word_t DATA_KEY   = 32'hC3A5_5A3C;
    // requests per test in test order
    localparam int    NUM_REQ    = 16 + 4 + 6 + 4 + 8 + 40;

    logic       clk, arst_n, req_valid, req_ready, rsp_valid, stall, stall_on, stall_nxt;
    logic       mem_req, mem_uncached, mem_addr_ok, mem_data_ok;
    fetch_req_t req;
    fetch_rsp_t rsp, held_rsp, exp_rsp;
    addr_t      mem_addr, a;
    line_t      mem_rdata;
    logic       held;
    logic       miss;
    logic [32:0] exp_mem;

    tag_t        sh_tag [WAYS][SETS];
    logic        sh_valid [WAYS][SETS];
    logic        sh_lru [SETS];
    logic [15:0] lfsr = 16'd70;
    fetch_rsp_t  exp_q[$];
    logic [32:0] mem_q[$];
    int          errors, err_mark, test_no, rsp_count, fetch_count, mem_count;

    icache_clk_gen #(.PERIOD(CLK_PERIOD)) clk_gen0 (.clk(clk));

    icache_mem_model #(.DATA_KEY(DATA_KEY)) mem0 (
        .clk(clk), .mem_req(mem_req), .mem_addr(mem_addr), .mem_uncached(mem_uncached),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata)
    );

    icache_top dut0 (
        .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req(req),
        .req_ready(req_ready), .rsp_valid(rsp_valid), .rsp(rsp), .stall(stall),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_uncached(mem_uncached),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t word_at(addr_t x);
        return {2'b00, x[31:2]} ^ DATA_KEY;
    endfunction

    // reference response from the alignment rule
    function automatic fetch_rsp_t expected_rsp(addr_t x, logic unc);
        fetch_rsp_t r;
        r.pc           = x;
        r.instr0       = word_at(x);
        r.instr1       = word_at(x + 32'd4);
        r.instr1_valid = !unc && !x[2];
        return r;
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // shadow tags, valid bits and lru decide hit or miss
    task automatic shadow_access(input addr_t x, input logic unc, output logic m);
        index_t idx;
        tag_t   t;
        logic   v;
        idx = x[7:4];
        t   = x[31:8];
        m   = 1'b1;
        if (!unc) begin
            for (int w = 0; w < WAYS; w++) begin
                if (sh_valid[w][idx] && sh_tag[w][idx] == t) begin
                    m = 1'b0;
                    sh_lru[idx] = (w == 0);
                end
            end
            if (m) begin
                v = sh_lru[idx];
                sh_tag[v][idx]   = t;
                sh_valid[v][idx] = 1'b1;
                sh_lru[idx]      = !v;
            end
        end
    endtask

    task automatic send_req(input fetch_req_t r);
        req       = r;
        req_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!req_ready);
        @(posedge clk);
        #10;
        req_valid = 1'b0;
    endtask

    task automatic issue_fetch(input addr_t x, input logic unc);
        fetch_req_t r;
        shadow_access(x, unc, miss);
        exp_q.push_back(expected_rsp(x, unc));
        if (miss) begin
            mem_q.push_back({unc, unc ? {x[31:2], 2'b00} : {x[31:4], 4'b0000}});
        end
        fetch_count++;
        r = '{addr: x, uncached: unc, is_op: 1'b0, op: OP_INV_SET};
        send_req(r);
    endtask

    task automatic issue_op(input addr_t x, input cache_op_e op);
        fetch_req_t r;
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                if (op == OP_INV_ALL || s == int'(x[7:4])) begin
                    sh_valid[w][s] = 1'b0;
                end
            end
        end
        r = '{addr: x, uncached: 1'b0, is_op: 1'b1, op: op};
        send_req(r);
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0 || mem_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #10;
        test_no++;
        $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
        err_mark = errors;
    endtask

    ////////////////////////////////////////
    // compare process sampled mid cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (arst_n) begin
            if (held) begin
                check_value("rsp_valid under stall", rsp_valid, 1'b1);
                check_value("rsp under stall", rsp, held_rsp);
            end
            if (stall) begin
                check_value("req_ready under stall", req_ready, 1'b0);
            end
            held     = rsp_valid && stall;
            held_rsp = rsp;
            if (rsp_valid && !stall) begin
                rsp_count++;
                if (exp_q.size() == 0) begin
                    $display("response at %0t ns arrived with no fetch outstanding", $time);
                    errors++;
                end else begin
                    exp_rsp = exp_q.pop_front();
                    check_value("pc", rsp.pc, exp_rsp.pc);
                    check_value("instr0", rsp.instr0, exp_rsp.instr0);
                    check_value("instr1_valid", rsp.instr1_valid, exp_rsp.instr1_valid);
                    if (exp_rsp.instr1_valid) begin
                        check_value("instr1", rsp.instr1, exp_rsp.instr1);
                    end
                end
            end
            if (mem_req && mem_addr_ok) begin
                mem_count++;
                if (mem_q.size() == 0) begin
                    $display("memory request at %0t ns was not a predicted miss", $time);
                    errors++;
                end else begin
                    exp_mem = mem_q.pop_front();
                    check_value("mem_addr", mem_addr, exp_mem[31:0]);
                    check_value("mem_uncached", mem_uncached, exp_mem[32]);
                end
            end
        end
    end

    // random stall drawn ahead of the stimulus draws of the same cycle
    initial begin
        stall     = 1'b0;
        stall_nxt = 1'b0;
        forever begin
            @(posedge clk);
            #5 stall_nxt = stall_on ? (rand_bits(2) < 2) : 1'b0;
            #5 stall = stall_nxt;
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_REQ * 20 + 200));
        $display("timeout: the run did not finish in the expected time");
        $display("Test FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        req_valid = 1'b0;
        req       = '0;
        arst_n    = 1'b0;
        stall_on  = 1'b0;
        held      = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            sh_lru[s] = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                sh_valid[w][s] = 1'b0;
                sh_tag[w][s]   = '0;
            end
        end
        repeat (5) @(posedge clk);
        #10;
        arst_n = 1'b1;

        for (int i = 0; i < 8; i++) issue_fetch(32'h1000 + i * 16, 1'b0);
        for (int i = 0; i < 8; i++) issue_fetch(32'h1008 + i * 16, 1'b0);
        finish_test("cold misses then hits");

        for (int i = 0; i < 4; i++) issue_fetch(32'h2080 + i * 4, 1'b0);
        finish_test("dual issue alignment");

        // three tags in set 5
        issue_fetch(32'h3050, 1'b0);
        issue_fetch(32'h4050, 1'b0);
        issue_fetch(32'h3054, 1'b0);
        issue_fetch(32'h5050, 1'b0);
        // kept line hits, evicted line misses
        issue_fetch(32'h3058, 1'b0);
        issue_fetch(32'h4058, 1'b0);
        finish_test("replacement");

        issue_fetch(32'h6094, 1'b1);
        issue_fetch(32'h6098, 1'b1);
        issue_fetch(32'h6090, 1'b0);
        issue_fetch(32'h6090, 1'b1);
        finish_test("uncached fetches");

        issue_fetch(32'h70A0, 1'b0);
        issue_fetch(32'h70B0, 1'b0);
        issue_op(32'h70A0, OP_INV_SET);
        issue_fetch(32'h70A4, 1'b0);
        issue_fetch(32'h70B4, 1'b0);
        issue_op(32'h0, OP_INV_ALL);
        issue_fetch(32'h70A8, 1'b0);
        issue_fetch(32'h70B8, 1'b0);
        finish_test("maintenance");

        stall_on = 1'b1;
        for (int i = 0; i < 40; i++) begin
            a = 32'h0001_0000 | (32'(rand_bits(2)) << 8) | (32'(rand_bits(3)) << 4)
                | (32'(rand_bits(2)) << 2);
            issue_fetch(a, rand_bits(3) == 16'd7);
        end
        stall_on = 1'b0;
        finish_test("random stall");

        check_value("responses against fetches", rsp_count, fetch_count);
        $display("fetches %0d responses %0d memory requests %0d errors %0d",
                 fetch_count, rsp_count, mem_count, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/icache_pkg.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_lru.sv
hdl/icache_ctrl.sv
hdl/icache_fetch_align.sv
hdl/icache_top.sv
verif/icache_clk_gen.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= icache_tb
RTL_TOP   ?= icache_top
FILELIST  ?= tb.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
